// ==== flist.f ====
rtl/pet_pkg.sv
rtl/pet_ram.sv
rtl/keyboard_matrix.sv
rtl/crtc_regs.sv
rtl/control_regs.sv
rtl/host_port.sv
rtl/cpu_port.sv
rtl/pet_bus_top.sv
tests/clock_gen.sv
tests/bus_checker.sv
tests/pet_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PET bus testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pet_bus_tb \
    -f flist.f \
    -o sim_pet_bus

./obj_dir/sim_pet_bus | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation run succeeded"
    exit 0
else
    echo "Simulation run did not succeed"
    exit 1
fi

// ==== tests/pet_bus_tb.sv ====
// Top of the PET bus testbench.
// Builds a table of host and CPU accesses with expected results, applies
// each entry as one strobe plus one idle cycle and prints the totals.
`timescale 1ns/1ps

module pet_bus_tb import pet_pkg::*; ;
    localparam int         CLK_PERIOD  = 20;
    localparam int         MAX_ENTRIES = 256;
    localparam logic [1:0] CHK_NONE    = 2'd0;
    localparam logic [1:0] CHK_DATA    = 2'd1;
    localparam logic [1:0] CHK_CTRL    = 2'd2;

    logic        sys_clock, rst_n;
    logic        host_stb, host_we, cpu_stb, cpu_we, cfg_crt, cfg_keyboard;
    logic [19:0] host_addr;
    logic [15:0] cpu_addr;
    logic [7:0]  host_wdata, cpu_wdata, host_rdata, cpu_rdata;
    logic        cpu_reset_n, cpu_ready;
    logic [1:0]  chk_kind;
    logic [7:0]  chk_exp;
    int          chk_id, checks, errors, n_entries, n_checked, seed, run_idx;
    logic        table_ready;
    logic [1:0]  cur_cfg;

    // Stimulus table, one strobe per entry
    logic        e_port  [MAX_ENTRIES];
    logic        e_we    [MAX_ENTRIES];
    logic [19:0] e_addr  [MAX_ENTRIES];
    logic [7:0]  e_wdata [MAX_ENTRIES];
    logic [1:0]  e_kind  [MAX_ENTRIES];
    logic [7:0]  e_exp   [MAX_ENTRIES];
    logic [1:0]  e_cfg   [MAX_ENTRIES];

    logic [7:0]  ram_shadow [int];
    logic [7:0]  kbd_shadow [KBD_COL_COUNT];

    clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) i_clock (
        .sys_clock_o(sys_clock), .rst_n_o(rst_n)
    );

    pet_bus_top i_dut (
        .sys_clock_i(sys_clock), .rst_n_i(rst_n),
        .host_stb_i(host_stb), .host_we_i(host_we), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
        .cpu_stb_i(cpu_stb), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
        .cpu_wdata_i(cpu_wdata), .cpu_rdata_o(cpu_rdata),
        .cfg_crt_i(cfg_crt), .cfg_keyboard_i(cfg_keyboard),
        .cpu_reset_n_o(cpu_reset_n), .cpu_ready_o(cpu_ready)
    );

    bus_checker i_checker (
        .sys_clock_i(sys_clock), .rst_n_i(rst_n), .cpu_stb_i(cpu_stb),
        .kind_i(chk_kind), .exp_i(chk_exp), .test_id_i(chk_id),
        .host_rdata_i(host_rdata), .cpu_rdata_i(cpu_rdata),
        .cpu_reset_n_i(cpu_reset_n), .cpu_ready_i(cpu_ready),
        .checks_o(checks), .errors_o(errors)
    );

    function automatic logic [19:0] ram_addr(input logic [16:0] offset);
        return {BANK_RAM, offset};
    endfunction

    function automatic logic [19:0] reg_addr(input logic [2:0] bank, input logic [7:0] idx);
        return {bank, 9'd0, idx};
    endfunction

    task automatic store_entry(input logic port, input logic we, input logic [19:0] addr,
                               input logic [7:0] wdata, input logic [1:0] kind,
                               input logic [7:0] exp);
        e_port[n_entries]  = port;
        e_we[n_entries]    = we;
        e_addr[n_entries]  = addr;
        e_wdata[n_entries] = wdata;
        e_kind[n_entries]  = kind;
        e_exp[n_entries]   = exp;
        e_cfg[n_entries]   = cur_cfg;
        if (kind != CHK_NONE) n_checked++;
        n_entries++;
    endtask

    task automatic host_wr(input logic [19:0] addr, input logic [7:0] d);
        store_entry(1'b0, 1'b1, addr, d, CHK_NONE, 8'h00);
    endtask

    task automatic host_rd(input logic [19:0] addr, input logic [7:0] exp);
        store_entry(1'b0, 1'b0, addr, 8'h00, CHK_DATA, exp);
    endtask

    task automatic host_ram_wr(input logic [16:0] offset, input logic [7:0] d);
        host_wr(ram_addr(offset), d);
        ram_shadow[int'(offset)] = d;
    endtask

    task automatic host_ram_rd(input logic [16:0] offset);
        host_rd(ram_addr(offset), ram_shadow[int'(offset)]);
    endtask

    // Every CPU write also lands in RAM, I/O addresses included
    task automatic cpu_wr(input logic [15:0] addr, input logic [7:0] d);
        store_entry(1'b1, 1'b1, {4'd0, addr}, d, CHK_NONE, 8'h00);
        ram_shadow[int'(addr)] = d;
    endtask

    task automatic cpu_rd(input logic [15:0] addr, input logic [7:0] exp);
        store_entry(1'b1, 1'b0, {4'd0, addr}, 8'h00, CHK_DATA, exp);
    endtask

    task automatic build_table();
        logic [16:0] off;
        logic [15:0] ca;
        logic [7:0]  d;
        logic [7:0]  st;
        int          i;
        // Reset levels, then hold in reset, then release and ready
        store_entry(1'b0, 1'b0, reg_addr(BANK_REG, REG_CPU), 8'h00, CHK_CTRL, 8'h00);
        store_entry(1'b0, 1'b1, reg_addr(BANK_REG, REG_CPU), 8'h02, CHK_CTRL, 8'h00);
        store_entry(1'b0, 1'b1, reg_addr(BANK_REG, REG_CPU), 8'h01, CHK_CTRL, 8'h03);
        host_rd(reg_addr(BANK_REG, REG_CPU), 8'h01);
        for (i = 0; i < 4; i++) begin
            st = 8'h00;
            st[REG_STATUS_CRT_BIT]      = i[0];
            st[REG_STATUS_KEYBOARD_BIT] = i[1];
            cur_cfg = 2'(i);
            host_rd(reg_addr(BANK_REG, REG_STATUS), st);
        end
        cur_cfg = 2'b00;
        for (i = 0; i < 6; i++) begin
            off = 17'($random(seed));
            d   = 8'($random(seed));
            host_ram_wr(off, d);
            host_ram_rd(off);
        end
        // Low half of the CPU map, clear of the I/O page
        for (i = 0; i < 4; i++) begin
            ca = 16'($random(seed)) & 16'h7FFF;
            d  = 8'($random(seed));
            cpu_wr(ca, d);
            host_ram_rd(17'(ca));
            cpu_rd(ca, d);
        end
        for (i = 0; i < KBD_COL_COUNT; i++) begin
            d = 8'(i * 37 + 17);
            kbd_shadow[i] = d;
            host_wr(reg_addr(BANK_KBD, 8'(i)), d);
            cpu_wr(PIA1_BASE + PIA_PORTA, 8'(i));
            cpu_rd(PIA1_BASE + PIA_PORTB, d);
            host_rd(reg_addr(BANK_KBD, 8'(i)), d);
        end
        host_ram_wr(17'(PIA1_BASE + PIA_PORTA), 8'hA5);
        host_ram_wr(17'(PIA1_BASE + PIA_PORTB), 8'h3C);
        host_ram_rd(17'(PIA1_BASE + PIA_PORTA));
        host_ram_rd(17'(PIA1_BASE + PIA_PORTB));
        cpu_rd(PIA1_BASE + PIA_PORTB, kbd_shadow[KBD_COL_COUNT-1]);
        for (i = 0; i < CRTC_REG_COUNT; i++) begin
            d = 8'(8'hC3 ^ (i * 5));
            cpu_wr(CRTC_ADDR, 8'(i));
            cpu_wr(CRTC_DATA, d);
            host_rd(reg_addr(BANK_CRTC, 8'(i)), d);
        end
        for (i = 0; i < CRTC_REG_COUNT; i++) begin
            d = 8'(i * 11 + 3);
            host_wr(reg_addr(BANK_CRTC, 8'(i)), d);
            host_rd(reg_addr(BANK_CRTC, 8'(i)), d);
        end
        cpu_rd(CRTC_ADDR, 8'h00);
        cpu_rd(CRTC_DATA, 8'h00);
        // Unused bank reads as zero
        host_rd({3'd5, 17'd0}, 8'h00);
    endtask

    task automatic apply_entry(input int idx);
        @(posedge sys_clock);
        #2;
        host_stb     = !e_port[idx];
        cpu_stb      = e_port[idx];
        host_we      = e_we[idx];
        cpu_we       = e_we[idx];
        host_addr    = e_addr[idx];
        cpu_addr     = e_addr[idx][15:0];
        host_wdata   = e_wdata[idx];
        cpu_wdata    = e_wdata[idx];
        cfg_crt      = e_cfg[idx][0];
        cfg_keyboard = e_cfg[idx][1];
        chk_kind     = e_kind[idx];
        chk_exp      = e_exp[idx];
        chk_id       = idx;
        @(posedge sys_clock);
        #2;
        host_stb = 1'b0;
        cpu_stb  = 1'b0;
        chk_kind = CHK_NONE;
    endtask

    initial begin
        host_stb     = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        cpu_stb      = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cfg_crt      = 1'b0;
        cfg_keyboard = 1'b0;
        chk_kind     = CHK_NONE;
        chk_exp      = '0;
        chk_id       = 0;
        cur_cfg      = 2'b00;
        n_entries    = 0;
        n_checked    = 0;
        seed         = 82202;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n);
        for (run_idx = 0; run_idx < n_entries; run_idx++) begin
            apply_entry(run_idx);
        end
        repeat (2) @(posedge sys_clock);
        $display("Totals: %0d entries, %0d checks, %0d errors", n_entries, checks, errors);
        if (errors == 0 && checks == n_checked) begin
            $display("Verification passed");
        end else begin
            if (checks != n_checked) begin
                $display("Only %0d of %0d expected checks were made", checks, n_checked);
            end
            $display("Verification failed");
        end
        $finish;
    end

    // Two cycles per entry plus a margin for reset
    initial begin
        wait (table_ready);
        #(n_entries * 2 * CLK_PERIOD + 1000);
        $display("Timeout: the table did not finish within its time budget");
        $display("Verification failed");
        $finish;
    end
endmodule

// ==== tests/bus_checker.sv ====
// Response checker for the PET bus testbench.
// Latches the expected value given with a strobe and compares the read data
// or the CPU control outputs on the following cycle. Prints one line per test.
`timescale 1ns/1ps

module bus_checker (
    input  logic       sys_clock_i,
    input  logic       rst_n_i,
    input  logic       cpu_stb_i,
    input  logic [1:0] kind_i,
    input  logic [7:0] exp_i,
    input  int         test_id_i,
    input  logic [7:0] host_rdata_i,
    input  logic [7:0] cpu_rdata_i,
    input  logic       cpu_reset_n_i,
    input  logic       cpu_ready_i,
    output int         checks_o,
    output int         errors_o
);
    localparam logic [1:0] CHK_NONE = 2'd0;
    localparam logic [1:0] CHK_CTRL = 2'd2;

    logic [1:0] kind_q;
    logic [7:0] exp_q;
    logic [7:0] got;
    logic       cpu_q;
    int         id_q;

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

    // Strobe seen on a rising edge has its result stable by the next falling edge
    always begin
        @(posedge sys_clock_i);
        if (rst_n_i && kind_i != CHK_NONE) begin
            kind_q = kind_i;
            exp_q  = exp_i;
            cpu_q  = cpu_stb_i;
            id_q   = test_id_i;
            @(negedge sys_clock_i);
            if (kind_q == CHK_CTRL) begin
                got = {6'b0, cpu_ready_i, cpu_reset_n_i};
            end else begin
                got = cpu_q ? cpu_rdata_i : host_rdata_i;
            end
            checks_o = checks_o + 1;
            if (got !== exp_q) begin
                errors_o = errors_o + 1;
                $display("Error at %0d ns: test %0d %s got %02h, expected %02h", $time, id_q,
                         (kind_q == CHK_CTRL) ? "ready/reset_n" :
                         (cpu_q ? "cpu read" : "host read"), got, exp_q);
            end else begin
                $display("Test %0d ok: %02h", id_q, got);
            end
        end
    end
endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock and reset source.
// Free-running clock of PERIOD_NS, reset held low for RESET_CYCLES cycles.
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic sys_clock_o,
    output logic rst_n_o
);
    initial begin
        sys_clock_o = 1'b0;
        forever #(PERIOD_NS / 2) sys_clock_o = ~sys_clock_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        #(PERIOD_NS * RESET_CYCLES);
        rst_n_o = 1'b1;
    end
endmodule

// ==== rtl/pet_bus_top.sv ====
// System bus of the PET machine with a host port and a CPU port.
// Both masters use one-cycle strobes; read data follows one cycle later.
// Depths of RAM, keyboard matrix and CRTC file are set here.
`timescale 1ns/1ps

module pet_bus_top import pet_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = pet_pkg::RAM_ADDR_WIDTH,
    parameter int KBD_COL_COUNT  = pet_pkg::KBD_COL_COUNT,
    parameter int CRTC_REG_COUNT = pet_pkg::CRTC_REG_COUNT,
    localparam int COL_W = $clog2(KBD_COL_COUNT),
    localparam int IDX_W = $clog2(CRTC_REG_COUNT)
) (
    input  logic                       sys_clock_i,
    input  logic                       rst_n_i,
    input  logic                       host_stb_i,
    input  logic                       host_we_i,
    input  logic [HOST_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [DATA_WIDTH-1:0]      host_wdata_i,
    output logic [DATA_WIDTH-1:0]      host_rdata_o,
    input  logic                       cpu_stb_i,
    input  logic                       cpu_we_i,
    input  logic [CPU_ADDR_WIDTH-1:0]  cpu_addr_i,
    input  logic [DATA_WIDTH-1:0]      cpu_wdata_i,
    output logic [DATA_WIDTH-1:0]      cpu_rdata_o,
    input  logic                       cfg_crt_i,
    input  logic                       cfg_keyboard_i,
    output logic                       cpu_reset_n_o,
    output logic                       cpu_ready_o
);
    logic                      hr_stb, hr_we, hk_stb, hk_we, hc_stb, hc_we, hg_stb, hg_we;
    logic [RAM_ADDR_WIDTH-1:0] hr_addr, cr_addr;
    logic [COL_W-1:0]          hk_col;
    logic [IDX_W-1:0]          hc_idx;
    logic [7:0]                hg_idx;
    logic [DATA_WIDTH-1:0]     hr_wdata, hk_wdata, hc_wdata, hg_wdata;
    logic [DATA_WIDTH-1:0]     hr_rdata, hk_rdata, hc_rdata, hg_rdata;
    logic                      cr_stb, cr_we, kbd_sel_stb, crtc_idx_stb, crtc_data_stb;
    logic [DATA_WIDTH-1:0]     cr_wdata, cr_rdata, ck_rdata;

    host_port #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
        .KBD_COL_COUNT (KBD_COL_COUNT),
        .CRTC_REG_COUNT(CRTC_REG_COUNT)
    ) i_host_port (
        .sys_clock_i, .rst_n_i, .host_stb_i, .host_we_i, .host_addr_i, .host_wdata_i,
        .ram_stb_o(hr_stb), .ram_we_o(hr_we), .ram_addr_o(hr_addr), .ram_wdata_o(hr_wdata),
        .kbd_stb_o(hk_stb), .kbd_we_o(hk_we), .kbd_col_o(hk_col), .kbd_wdata_o(hk_wdata),
        .crtc_stb_o(hc_stb), .crtc_we_o(hc_we), .crtc_idx_o(hc_idx), .crtc_wdata_o(hc_wdata),
        .ctrl_stb_o(hg_stb), .ctrl_we_o(hg_we), .ctrl_idx_o(hg_idx), .ctrl_wdata_o(hg_wdata),
        .ram_rdata_i(hr_rdata), .kbd_rdata_i(hk_rdata), .crtc_rdata_i(hc_rdata),
        .ctrl_rdata_i(hg_rdata), .host_rdata_o
    );

    cpu_port #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_cpu_port (
        .sys_clock_i, .rst_n_i, .cpu_stb_i, .cpu_we_i, .cpu_addr_i, .cpu_wdata_i,
        .ram_stb_o(cr_stb), .ram_we_o(cr_we), .ram_addr_o(cr_addr), .ram_wdata_o(cr_wdata),
        .kbd_sel_stb_o(kbd_sel_stb), .crtc_idx_stb_o(crtc_idx_stb),
        .crtc_data_stb_o(crtc_data_stb), .ram_rdata_i(cr_rdata), .kbd_rdata_i(ck_rdata),
        .cpu_rdata_o
    );

    // CPU on port a so that it wins same-address writes
    pet_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_ram (
        .sys_clock_i,
        .a_stb_i(cr_stb), .a_we_i(cr_we), .a_addr_i(cr_addr), .a_wdata_i(cr_wdata),
        .a_rdata_o(cr_rdata),
        .b_stb_i(hr_stb), .b_we_i(hr_we), .b_addr_i(hr_addr), .b_wdata_i(hr_wdata),
        .b_rdata_o(hr_rdata)
    );

    keyboard_matrix #(.KBD_COL_COUNT(KBD_COL_COUNT)) i_kbd (
        .sys_clock_i, .rst_n_i,
        .host_stb_i(hk_stb), .host_we_i(hk_we), .host_col_i(hk_col),
        .host_wdata_i(hk_wdata), .host_rdata_o(hk_rdata),
        .sel_stb_i(kbd_sel_stb), .sel_col_i(cpu_wdata_i[3:0]), .cpu_rdata_o(ck_rdata)
    );

    crtc_regs #(.CRTC_REG_COUNT(CRTC_REG_COUNT)) i_crtc (
        .sys_clock_i, .rst_n_i,
        .host_stb_i(hc_stb), .host_we_i(hc_we), .host_idx_i(hc_idx),
        .host_wdata_i(hc_wdata), .host_rdata_o(hc_rdata),
        .idx_stb_i(crtc_idx_stb), .data_stb_i(crtc_data_stb), .cpu_wdata_i
    );

    control_regs i_ctrl (
        .sys_clock_i, .rst_n_i,
        .stb_i(hg_stb), .we_i(hg_we), .idx_i(hg_idx), .wdata_i(hg_wdata), .rdata_o(hg_rdata),
        .cfg_crt_i, .cfg_keyboard_i, .cpu_reset_n_o, .cpu_ready_o
    );
endmodule

// ==== rtl/cpu_port.sv ====
// CPU side decoder. All writes land in RAM; PIA1 and CRTC addresses also
// strobe the keyboard latch and CRTC file. Read data follows one cycle later.
`timescale 1ns/1ps

module cpu_port import pet_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = pet_pkg::RAM_ADDR_WIDTH
) (
    input  logic                      sys_clock_i,
    input  logic                      rst_n_i,
    input  logic                      cpu_stb_i,
    input  logic                      cpu_we_i,
    input  logic [CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [DATA_WIDTH-1:0]     cpu_wdata_i,
    output logic                      ram_stb_o,
    output logic                      ram_we_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic [DATA_WIDTH-1:0]     ram_wdata_o,
    output logic                      kbd_sel_stb_o,
    output logic                      crtc_idx_stb_o,
    output logic                      crtc_data_stb_o,
    input  logic [DATA_WIDTH-1:0]     ram_rdata_i,
    input  logic [DATA_WIDTH-1:0]     kbd_rdata_i,
    output logic [DATA_WIDTH-1:0]     cpu_rdata_o
);
    typedef enum logic [1:0] {SRC_RAM, SRC_KBD, SRC_ZERO} src_e;

    logic hit_porta, hit_portb, hit_crtc_a, hit_crtc_d, rd;
    src_e src_q;

    assign hit_porta  = cpu_addr_i == PIA1_BASE + PIA_PORTA;
    assign hit_portb  = cpu_addr_i == PIA1_BASE + PIA_PORTB;
    assign hit_crtc_a = cpu_addr_i == CRTC_ADDR;
    assign hit_crtc_d = cpu_addr_i == CRTC_DATA;
    assign rd         = cpu_stb_i && !cpu_we_i;

    // Intercepted reads leave RAM alone
    assign ram_stb_o   = cpu_stb_i && (cpu_we_i || !(hit_portb || hit_crtc_a || hit_crtc_d));
    assign ram_we_o    = cpu_we_i;
    assign ram_addr_o  = RAM_ADDR_WIDTH'(cpu_addr_i);
    assign ram_wdata_o = cpu_wdata_i;

    assign kbd_sel_stb_o   = cpu_stb_i && cpu_we_i && hit_porta;
    assign crtc_idx_stb_o  = cpu_stb_i && cpu_we_i && hit_crtc_a;
    assign crtc_data_stb_o = cpu_stb_i && cpu_we_i && hit_crtc_d;

    always_ff @(posedge sys_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q <= SRC_ZERO;
        end else if (rd) begin
            if (hit_portb) src_q <= SRC_KBD;
            else if (hit_crtc_a || hit_crtc_d) src_q <= SRC_ZERO;
            else src_q <= SRC_RAM;
        end
    end

    assign cpu_rdata_o = (src_q == SRC_RAM) ? ram_rdata_i :
                         (src_q == SRC_KBD) ? kbd_rdata_i : '0;

    a_one_intercept: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        $onehot0({kbd_sel_stb_o, rd && hit_portb, crtc_idx_stb_o, crtc_data_stb_o,
                  rd && (hit_crtc_a || hit_crtc_d)}));
endmodule

// ==== rtl/host_port.sv ====
// Host side decoder. Splits a host strobe into one target strobe by bank
// and returns the matching read data on the following cycle.
`timescale 1ns/1ps

module host_port import pet_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = pet_pkg::RAM_ADDR_WIDTH,
    parameter int KBD_COL_COUNT  = pet_pkg::KBD_COL_COUNT,
    parameter int CRTC_REG_COUNT = pet_pkg::CRTC_REG_COUNT,
    localparam int COL_W = $clog2(KBD_COL_COUNT),
    localparam int IDX_W = $clog2(CRTC_REG_COUNT)
) (
    input  logic                       sys_clock_i,
    input  logic                       rst_n_i,
    input  logic                       host_stb_i,
    input  logic                       host_we_i,
    input  logic [HOST_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [DATA_WIDTH-1:0]      host_wdata_i,
    output logic                       ram_stb_o,
    output logic                       ram_we_o,
    output logic [RAM_ADDR_WIDTH-1:0]  ram_addr_o,
    output logic [DATA_WIDTH-1:0]      ram_wdata_o,
    output logic                       kbd_stb_o,
    output logic                       kbd_we_o,
    output logic [COL_W-1:0]           kbd_col_o,
    output logic [DATA_WIDTH-1:0]      kbd_wdata_o,
    output logic                       crtc_stb_o,
    output logic                       crtc_we_o,
    output logic [IDX_W-1:0]           crtc_idx_o,
    output logic [DATA_WIDTH-1:0]      crtc_wdata_o,
    output logic                       ctrl_stb_o,
    output logic                       ctrl_we_o,
    output logic [7:0]                 ctrl_idx_o,
    output logic [DATA_WIDTH-1:0]      ctrl_wdata_o,
    input  logic [DATA_WIDTH-1:0]      ram_rdata_i,
    input  logic [DATA_WIDTH-1:0]      kbd_rdata_i,
    input  logic [DATA_WIDTH-1:0]      crtc_rdata_i,
    input  logic [DATA_WIDTH-1:0]      ctrl_rdata_i,
    output logic [DATA_WIDTH-1:0]      host_rdata_o
);
    host_addr_u addr;
    logic [2:0] rd_bank_q;

    assign addr = host_addr_i;

    assign ram_stb_o  = host_stb_i && (addr.ram.bank == BANK_RAM);
    assign kbd_stb_o  = host_stb_i && (addr.regs.bank == BANK_KBD);
    assign crtc_stb_o = host_stb_i && (addr.regs.bank == BANK_CRTC);
    assign ctrl_stb_o = host_stb_i && (addr.regs.bank == BANK_REG);

    assign ram_we_o  = host_we_i;
    assign kbd_we_o  = host_we_i;
    assign crtc_we_o = host_we_i;
    assign ctrl_we_o = host_we_i;

    assign ram_addr_o = RAM_ADDR_WIDTH'(addr.ram.offset);
    assign kbd_col_o  = addr.regs.index[COL_W-1:0];
    assign crtc_idx_o = addr.regs.index[IDX_W-1:0];
    assign ctrl_idx_o = addr.regs.index;

    assign ram_wdata_o  = host_wdata_i;
    assign kbd_wdata_o  = host_wdata_i;
    assign crtc_wdata_o = host_wdata_i;
    assign ctrl_wdata_o = host_wdata_i;

    // Bank of the last read picks the returned byte until the next read
    always_ff @(posedge sys_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bank_q <= BANK_RAM;
        end else if (host_stb_i && !host_we_i) begin
            rd_bank_q <= addr.ram.bank;
        end
    end

    always_comb begin
        case (rd_bank_q)
            BANK_RAM:  host_rdata_o = ram_rdata_i;
            BANK_KBD:  host_rdata_o = kbd_rdata_i;
            BANK_CRTC: host_rdata_o = crtc_rdata_i;
            BANK_REG:  host_rdata_o = ctrl_rdata_i;
            default:   host_rdata_o = '0;
        endcase
    end

    a_we_known: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        host_stb_i |-> !$isunknown(host_we_i));
endmodule

// ==== rtl/control_regs.sv ====
// Host control bank. REG_CPU drives the CPU reset and ready lines,
// REG_STATUS reports the board configuration inputs.
`timescale 1ns/1ps

module control_regs import pet_pkg::*; (
    input  logic                  sys_clock_i,
    input  logic                  rst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [7:0]            idx_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic [DATA_WIDTH-1:0] rdata_o,
    input  logic                  cfg_crt_i,
    input  logic                  cfg_keyboard_i,
    output logic                  cpu_reset_n_o,
    output logic                  cpu_ready_o
);
    logic reset_q, ready_q;

    // CPU held in reset and not ready out of power-on
    always_ff @(posedge sys_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reset_q <= 1'b1;
            ready_q <= 1'b0;
        end else if (stb_i && we_i && idx_i == REG_CPU) begin
            reset_q <= wdata_i[REG_CPU_RESET_BIT];
            ready_q <= wdata_i[REG_CPU_READY_BIT];
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (stb_i && !we_i) begin
            rdata_o <= '0;
            if (idx_i == REG_CPU) begin
                rdata_o[REG_CPU_RESET_BIT] <= reset_q;
                rdata_o[REG_CPU_READY_BIT] <= ready_q;
            end else if (idx_i == REG_STATUS) begin
                rdata_o[REG_STATUS_CRT_BIT]      <= cfg_crt_i;
                rdata_o[REG_STATUS_KEYBOARD_BIT] <= cfg_keyboard_i;
            end
        end
    end

    assign cpu_reset_n_o = !reset_q;
    assign cpu_ready_o   = ready_q;
endmodule

// ==== rtl/crtc_regs.sv ====
// CRTC address latch and register file. The CPU writes through the
// index/data pair, the host reads and writes registers directly.
`timescale 1ns/1ps

module crtc_regs import pet_pkg::*; #(
    parameter int CRTC_REG_COUNT = pet_pkg::CRTC_REG_COUNT,
    localparam int IDX_W = $clog2(CRTC_REG_COUNT)
) (
    input  logic                  sys_clock_i,
    input  logic                  rst_n_i,
    input  logic                  host_stb_i,
    input  logic                  host_we_i,
    input  logic [IDX_W-1:0]      host_idx_i,
    input  logic [DATA_WIDTH-1:0] host_wdata_i,
    output logic [DATA_WIDTH-1:0] host_rdata_o,
    input  logic                  idx_stb_i,
    input  logic                  data_stb_i,
    input  logic [DATA_WIDTH-1:0] cpu_wdata_i
);
    logic [DATA_WIDTH-1:0] regs [CRTC_REG_COUNT];
    logic [IDX_W-1:0]      idx_q;

    always_ff @(posedge sys_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (idx_stb_i) begin
            idx_q <= cpu_wdata_i[IDX_W-1:0];
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (host_stb_i && host_we_i && host_idx_i < CRTC_REG_COUNT) begin
            regs[host_idx_i] <= host_wdata_i;
        end
        // Later assignment, so the CPU wins a collision
        if (data_stb_i && idx_q < CRTC_REG_COUNT) begin
            regs[idx_q] <= cpu_wdata_i;
        end
        if (host_stb_i && !host_we_i) begin
            host_rdata_o <= (host_idx_i < CRTC_REG_COUNT) ? regs[host_idx_i] : '0;
        end
    end
endmodule

// ==== rtl/keyboard_matrix.sv ====
// Keyboard column bytes, written by the host and scanned by the CPU.
// A CPU write to PIA1 port A selects the column read back on port B.
`timescale 1ns/1ps

module keyboard_matrix import pet_pkg::*; #(
    parameter int KBD_COL_COUNT = pet_pkg::KBD_COL_COUNT,
    localparam int COL_W = $clog2(KBD_COL_COUNT)
) (
    input  logic                  sys_clock_i,
    input  logic                  rst_n_i,
    input  logic                  host_stb_i,
    input  logic                  host_we_i,
    input  logic [COL_W-1:0]      host_col_i,
    input  logic [DATA_WIDTH-1:0] host_wdata_i,
    output logic [DATA_WIDTH-1:0] host_rdata_o,
    input  logic                  sel_stb_i,
    input  logic [3:0]            sel_col_i,
    output logic [DATA_WIDTH-1:0] cpu_rdata_o
);
    logic [DATA_WIDTH-1:0] cols [KBD_COL_COUNT];
    logic [3:0]            sel_q;

    always_ff @(posedge sys_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q <= '0;
        end else if (sel_stb_i) begin
            sel_q <= sel_col_i;
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (host_stb_i && host_we_i && host_col_i < KBD_COL_COUNT) begin
            cols[host_col_i] <= host_wdata_i;
        end
        if (host_stb_i && !host_we_i) begin
            host_rdata_o <= (host_col_i < KBD_COL_COUNT) ? cols[host_col_i] : '0;
        end
        // Selected column is refreshed every cycle, no keys down past the last column
        cpu_rdata_o <= (sel_q < KBD_COL_COUNT) ? cols[sel_q] : '0;
    end

    a_host_col_range: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        host_stb_i && host_we_i |-> host_col_i < KBD_COL_COUNT);
endmodule

// ==== rtl/pet_ram.sv ====
// Shared byte RAM with two ports and registered reads.
// Port a belongs to the CPU and wins a same-address write against port b.
`timescale 1ns/1ps

module pet_ram import pet_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = pet_pkg::RAM_ADDR_WIDTH
) (
    input  logic                      sys_clock_i,
    input  logic                      a_stb_i,
    input  logic                      a_we_i,
    input  logic [RAM_ADDR_WIDTH-1:0] a_addr_i,
    input  logic [DATA_WIDTH-1:0]     a_wdata_i,
    output logic [DATA_WIDTH-1:0]     a_rdata_o,
    input  logic                      b_stb_i,
    input  logic                      b_we_i,
    input  logic [RAM_ADDR_WIDTH-1:0] b_addr_i,
    input  logic [DATA_WIDTH-1:0]     b_wdata_i,
    output logic [DATA_WIDTH-1:0]     b_rdata_o
);
    logic [DATA_WIDTH-1:0] mem [2**RAM_ADDR_WIDTH];
    logic                  a_wr, b_wr;

    assign a_wr = a_stb_i && a_we_i;
    assign b_wr = b_stb_i && b_we_i && !(a_wr && a_addr_i == b_addr_i);

    always_ff @(posedge sys_clock_i) begin
        if (a_wr) mem[a_addr_i] <= a_wdata_i;
        if (b_wr) mem[b_addr_i] <= b_wdata_i;
        if (a_stb_i && !a_we_i) a_rdata_o <= mem[a_addr_i];
        if (b_stb_i && !b_we_i) b_rdata_o <= mem[b_addr_i];
    end
endmodule

// ==== rtl/pet_pkg.sv ====
// Shared widths, bank codes and register map of the PET system bus.
// Modules import it with a wildcard import in their header.
// The host address is a banked 20-bit word. It is read either as a RAM
// offset or as a register bank and index.
package pet_pkg;
    localparam int DATA_WIDTH      = 8;
    localparam int CPU_ADDR_WIDTH  = 16;
    localparam int HOST_ADDR_WIDTH = 20;
    localparam int RAM_ADDR_WIDTH  = 17;
    localparam int KBD_COL_COUNT   = 10;
    localparam int CRTC_REG_COUNT  = 18;

    // Host bank codes, top 3 bits of the host address
    localparam logic [2:0] BANK_RAM  = 3'd0;
    localparam logic [2:0] BANK_KBD  = 3'd1;
    localparam logic [2:0] BANK_CRTC = 3'd2;
    localparam logic [2:0] BANK_REG  = 3'd3;

    // CPU I/O addresses
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA1_BASE = 16'hE810;
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA_PORTA = 16'h0000;
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA_PORTB = 16'h0002;
    localparam logic [CPU_ADDR_WIDTH-1:0] CRTC_ADDR = 16'hE880;
    localparam logic [CPU_ADDR_WIDTH-1:0] CRTC_DATA = 16'hE881;

    // Control bank
    localparam logic [7:0] REG_CPU    = 8'd0;
    localparam logic [7:0] REG_STATUS = 8'd1;

    localparam int REG_CPU_READY_BIT       = 0;
    localparam int REG_CPU_RESET_BIT       = 1;
    localparam int REG_STATUS_CRT_BIT      = 0;
    localparam int REG_STATUS_KEYBOARD_BIT = 1;

    typedef union packed {
        struct packed {
            logic [2:0]                     bank;
            logic [HOST_ADDR_WIDTH-4:0]     offset;
        } ram;
        struct packed {
            logic [2:0] bank;
            logic [8:0] unused;
            logic [7:0] index;
        } regs;
    } host_addr_u;
endpackage
